/* ethCrc.sv */
`default_nettype none

module ethCrc
(
  input  wire                               MRxClk,
  input  wire                               Reset,
  input  wire [7:0]                         RxByte,
  input  wire                               StateData,
  input  wire [ethRxPkg::ByteCntWidth-1:0]  ByteCnt,
  output logic [5:0]                        CrcHash,
  output logic                              CrcHashGood
);

  logic [31:0] Crc;
  logic [31:0] CrcNext;

  // One byte through the reflected CRC-32, least significant bit first
  function automatic logic [31:0] crcByte(input logic [31:0] CrcIn, input logic [7:0] DataIn);
    logic [31:0] Acc;
    int          i;
    Acc = CrcIn;
    for (i = 0; i < 8; i++)
    begin
      if (Acc[0] ^ DataIn[i])
        Acc = (Acc >> 1) ^ ethRxPkg::CrcPoly;
      else
        Acc = Acc >> 1;
    end
    return Acc;
  endfunction

  assign CrcNext = crcByte(Crc, RxByte);

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      Crc <= '1;
    else if (ByteCnt == 0)
      Crc <= '1;                                            // Also covers the SFD cycle
    else if (StateData && ByteCnt <= 6)
      Crc <= CrcNext;                                       // Only the six destination bytes
  end

  // The last destination byte is on RxByte at ByteCnt 6, so the hash
  // comes straight from the updated value instead of the register
  assign CrcHash     = CrcNext[31:26];
  assign CrcHashGood = StateData && (ByteCnt == 6);

endmodule

`default_nettype wire

/* ethRxAddrCheck.sv */
`default_nettype none

module ethRxAddrCheck
(
  input  wire                    MRxClk,
  input  wire                    Reset,
  input  wire ethRxPkg::rxAddrCfg_t Cfg,
  input  wire [7:0]              RxData,
  input  wire                    Broadcast,
  input  wire                    Multicast,
  input  wire                    ByteCntEq0,
  input  wire                    ByteCntEq2,
  input  wire                    ByteCntEq3,
  input  wire                    ByteCntEq4,
  input  wire                    ByteCntEq5,
  input  wire                    ByteCntEq6,
  input  wire                    ByteCntEq7,
  input  wire [5:0]              CrcHash,
  input  wire                    CrcHashGood,
  input  wire                    StateData,
  input  wire                    RxEndFrm,
  input  wire                    ControlFrmAddressOK,
  output logic                   RxAbort,
  output logic                   AddressMiss
);

  logic [7:0]  MacByte;
  logic [31:0] HashWord;
  logic [7:0]  HashByte;
  logic        HashBit;
  logic        UnicastOK;                                   // Bytes compared so far all matched
  logic        UnicastHit;
  logic        MulticastOK;
  logic        MulticastHit;
  logic        BroadcastOK;
  logic        Rejected;

  // RxData lags RxByte by one cycle, so byte k is compared at ByteCnt k+2
  always_comb
  begin
    MacByte = Cfg.Mac[7:0];                                 // Last byte, seen at ByteCntEq7
    if (ByteCntEq2)
      MacByte = Cfg.Mac[47:40];
    else if (ByteCntEq3)
      MacByte = Cfg.Mac[39:32];
    else if (ByteCntEq4)
      MacByte = Cfg.Mac[31:24];
    else if (ByteCntEq5)
      MacByte = Cfg.Mac[23:16];
    else if (ByteCntEq6)
      MacByte = Cfg.Mac[15:8];
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      UnicastOK <= 1'b0;
    else if (StateData && ByteCntEq2)
      UnicastOK <= (RxData == MacByte);
    else if (StateData && (ByteCntEq3 || ByteCntEq4 || ByteCntEq5 || ByteCntEq6))
      UnicastOK <= UnicastOK && (RxData == MacByte);
    else if (RxEndFrm || RxAbort)
      UnicastOK <= 1'b0;
  end

  assign UnicastHit = UnicastOK && (RxData == MacByte);     // Includes the sixth byte

  assign HashWord = CrcHash[5] ? Cfg.Hash1 : Cfg.Hash0;

  always_comb
  begin
    unique case (CrcHash[4:3])
      2'b00: HashByte = HashWord[7:0];
      2'b01: HashByte = HashWord[15:8];
      2'b10: HashByte = HashWord[23:16];
      2'b11: HashByte = HashWord[31:24];
    endcase
  end

  assign HashBit = HashByte[CrcHash[2:0]];

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      MulticastOK <= 1'b0;
    else if (RxEndFrm || RxAbort)
      MulticastOK <= 1'b0;
    else if (CrcHashGood && Multicast)
      MulticastOK <= HashBit;
  end

  // Broadcast is governed by RBro alone, never by the hash table
  assign MulticastHit = MulticastOK && !Broadcast;
  assign BroadcastOK  = Broadcast && !Cfg.RBro;

  assign Rejected = !(UnicastHit || BroadcastOK || MulticastHit || Cfg.RPro);

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      RxAbort <= 1'b0;
    else
      RxAbort <= Rejected && ByteCntEq7 && StateData;       // Single cycle by construction
  end

  // Status miss ignores promiscuous mode but lets control frames through
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      AddressMiss <= 1'b0;
    else if (ByteCntEq0)
      AddressMiss <= 1'b0;
    else if (ByteCntEq7 && StateData)
      AddressMiss <= !(UnicastHit || BroadcastOK || MulticastHit ||
                       (Cfg.PassAll && ControlFrmAddressOK));
  end

  assert property (@(posedge MRxClk) disable iff (Reset)
    RxAbort |=> !RxAbort)
    else $error("RxAbort held for more than one cycle");

endmodule

`default_nettype wire

/* ethRxAddrFilter.sv */
`default_nettype none

module ethRxAddrFilter
(
  input  wire                       MRxClk,
  input  wire                       Reset,
  input  wire                       RxDv,
  input  wire [7:0]                 RxByte,
  input  wire ethRxPkg::rxAddrCfg_t Cfg,
  output logic                      RxAbort,
  output logic                      RxStatusValid,
  output ethRxPkg::rxFrameStatus_t  RxStatus
);

  logic                              StateData;
  logic                              SfdSeen;
  logic                              RxEndFrm;
  logic [7:0]                        RxData;
  logic [ethRxPkg::ByteCntWidth-1:0] ByteCnt;
  logic                              ByteCntEq0;
  logic                              ByteCntEq2;
  logic                              ByteCntEq3;
  logic                              ByteCntEq4;
  logic                              ByteCntEq5;
  logic                              ByteCntEq6;
  logic                              ByteCntEq7;
  logic                              Broadcast;
  logic                              Multicast;
  logic                              ControlFrmAddressOK;
  logic [5:0]                        CrcHash;
  logic                              CrcHashGood;
  logic                              AddressMiss;

  ethRxStateMachine u_ethRxStateMachine
  (
    .MRxClk    (MRxClk),
    .Reset     (Reset),
    .RxDv      (RxDv),
    .RxByte    (RxByte),
    .RxAbort   (RxAbort),
    .StateData (StateData),
    .SfdSeen   (SfdSeen),
    .RxEndFrm  (RxEndFrm),
    .State     ()                                           // Only observed inside the FSM
  );

  ethRxDataPath u_ethRxDataPath
  (
    .MRxClk              (MRxClk),
    .Reset               (Reset),
    .RxByte              (RxByte),
    .StateData           (StateData),
    .SfdSeen             (SfdSeen),
    .RxEndFrm            (RxEndFrm),
    .RxAbort             (RxAbort),
    .AddressMiss         (AddressMiss),
    .RxData              (RxData),
    .ByteCnt             (ByteCnt),
    .ByteCntEq0          (ByteCntEq0),
    .ByteCntEq2          (ByteCntEq2),
    .ByteCntEq3          (ByteCntEq3),
    .ByteCntEq4          (ByteCntEq4),
    .ByteCntEq5          (ByteCntEq5),
    .ByteCntEq6          (ByteCntEq6),
    .ByteCntEq7          (ByteCntEq7),
    .Broadcast           (Broadcast),
    .Multicast           (Multicast),
    .ControlFrmAddressOK (ControlFrmAddressOK),
    .RxStatusValid       (RxStatusValid),
    .RxStatus            (RxStatus)
  );

  ethCrc u_ethCrc
  (
    .MRxClk      (MRxClk),
    .Reset       (Reset),
    .RxByte      (RxByte),
    .StateData   (StateData),
    .ByteCnt     (ByteCnt),
    .CrcHash     (CrcHash),
    .CrcHashGood (CrcHashGood)
  );

  ethRxAddrCheck u_ethRxAddrCheck
  (
    .MRxClk              (MRxClk),
    .Reset               (Reset),
    .Cfg                 (Cfg),
    .RxData              (RxData),
    .Broadcast           (Broadcast),
    .Multicast           (Multicast),
    .ByteCntEq0          (ByteCntEq0),
    .ByteCntEq2          (ByteCntEq2),
    .ByteCntEq3          (ByteCntEq3),
    .ByteCntEq4          (ByteCntEq4),
    .ByteCntEq5          (ByteCntEq5),
    .ByteCntEq6          (ByteCntEq6),
    .ByteCntEq7          (ByteCntEq7),
    .CrcHash             (CrcHash),
    .CrcHashGood         (CrcHashGood),
    .StateData           (StateData),
    .RxEndFrm            (RxEndFrm),
    .ControlFrmAddressOK (ControlFrmAddressOK),
    .RxAbort             (RxAbort),
    .AddressMiss         (AddressMiss)
  );

endmodule

`default_nettype wire

/* ethRxDataPath.sv */
`default_nettype none

module ethRxDataPath
(
  input  wire                                 MRxClk,
  input  wire                                 Reset,
  input  wire [7:0]                           RxByte,
  input  wire                                 StateData,
  input  wire                                 SfdSeen,
  input  wire                                 RxEndFrm,
  input  wire                                 RxAbort,
  input  wire                                 AddressMiss,
  output logic [7:0]                          RxData,
  output logic [ethRxPkg::ByteCntWidth-1:0]   ByteCnt,
  output logic                                ByteCntEq0,
  output logic                                ByteCntEq2,
  output logic                                ByteCntEq3,
  output logic                                ByteCntEq4,
  output logic                                ByteCntEq5,
  output logic                                ByteCntEq6,
  output logic                                ByteCntEq7,
  output logic                                Broadcast,
  output logic                                Multicast,
  output logic                                ControlFrmAddressOK,
  output logic                                RxStatusValid,
  output ethRxPkg::rxFrameStatus_t            RxStatus
);

  logic       InFrame;                                      // From SFD up to and including RxEndFrm
  logic       AbortSeen;
  logic       FirstDest;
  logic       InDest;
  logic [7:0] ControlByte;

  always_ff @(posedge MRxClk)
  begin
    RxData <= RxByte;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      InFrame <= 1'b0;
      ByteCnt <= '0;
    end
    else if (RxEndFrm)
    begin
      InFrame <= 1'b0;
      ByteCnt <= '0;
    end
    else if (SfdSeen)
    begin
      InFrame <= 1'b1;
      ByteCnt <= 1'b1;                                      // Counting restarts at the delimiter
    end
    else if (InFrame && ByteCnt != '1)
      ByteCnt <= ByteCnt + 1'b1;                            // Saturates at all ones
  end

  assign ByteCntEq0 = (ByteCnt == 0);
  assign ByteCntEq2 = (ByteCnt == 2);
  assign ByteCntEq3 = (ByteCnt == 3);
  assign ByteCntEq4 = (ByteCnt == 4);
  assign ByteCntEq5 = (ByteCnt == 5);
  assign ByteCntEq6 = (ByteCnt == 6);
  assign ByteCntEq7 = (ByteCnt == 7);

  // Destination byte k sits on RxByte while ByteCnt is k+1
  assign FirstDest = StateData && (ByteCnt == 1);
  assign InDest    = StateData && (ByteCnt >= 1) && (ByteCnt <= 6);

  always_comb
  begin
    unique case (ByteCnt[2:0])
      3'd1:    ControlByte = ethRxPkg::ControlAddr[47:40];
      3'd2:    ControlByte = ethRxPkg::ControlAddr[39:32];
      3'd3:    ControlByte = ethRxPkg::ControlAddr[31:24];
      3'd4:    ControlByte = ethRxPkg::ControlAddr[23:16];
      3'd5:    ControlByte = ethRxPkg::ControlAddr[15:8];
      3'd6:    ControlByte = ethRxPkg::ControlAddr[7:0];
      default: ControlByte = 8'h00;
    endcase
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      Broadcast           <= 1'b0;
      Multicast           <= 1'b0;
      ControlFrmAddressOK <= 1'b0;
    end
    else if (SfdSeen)
    begin
      Broadcast           <= 1'b0;
      Multicast           <= 1'b0;
      ControlFrmAddressOK <= 1'b0;
    end
    else if (InDest)
    begin
      Broadcast           <= (FirstDest || Broadcast) && (RxByte == 8'hFF);
      ControlFrmAddressOK <= (FirstDest || ControlFrmAddressOK) && (RxByte == ControlByte);
      if (FirstDest)
        Multicast <= RxByte[0];                             // Group bit of the first byte
    end
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      AbortSeen <= 1'b0;
    else if (SfdSeen)
      AbortSeen <= 1'b0;
    else if (RxAbort)
      AbortSeen <= 1'b1;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      RxStatusValid <= 1'b0;
    else
      RxStatusValid <= RxEndFrm;
  end

  always_ff @(posedge MRxClk)
  begin
    if (RxEndFrm)
    begin
      RxStatus.AddressMiss <= AddressMiss;
      RxStatus.Aborted     <= AbortSeen || RxAbort;
      RxStatus.Broadcast   <= Broadcast;
      RxStatus.Multicast   <= Multicast;
      RxStatus.Length      <= ByteCnt - 1'b1;               // ByteCnt already counts the RxEndFrm cycle
    end
  end

  // The address checker needs one new window flag in every Data cycle
  assert property (@(posedge MRxClk) disable iff (Reset)
    (StateData && !RxEndFrm && ByteCnt != '1) |=> (ByteCnt == $past(ByteCnt) + 1'b1))
    else $error("Byte counter did not advance in a Data cycle");

endmodule

`default_nettype wire

/* ethRxPkg.sv */
`default_nettype none

package ethRxPkg;

  localparam logic [7:0] SfdByte = 8'hD5;                   // Start-of-frame delimiter
  localparam logic [7:0] PreambleByte = 8'h55;

  localparam int ByteCntWidth = 16;                         // Enough for jumbo frames

  // Destination used by PAUSE and other MAC control frames
  localparam logic [47:0] ControlAddr = 48'h0180_C200_0001;

  localparam logic [31:0] CrcPoly = 32'hEDB8_8320;          // Reflected CRC-32 polynomial

  typedef enum logic [1:0]
  {
    Idle,
    Preamble,
    Data,
    Drop                                                    // Rejected frame, waiting for RxDv low
  } rxState_t;

  typedef struct packed
  {
    logic [47:0] Mac;                                       // Station address, first byte in [47:40]
    logic [31:0] Hash0;                                     // Hash table entries 0 to 31
    logic [31:0] Hash1;                                     // Hash table entries 32 to 63
    logic        RBro;                                      // Reject broadcast
    logic        RPro;                                      // Promiscuous mode
    logic        PassAll;                                   // Accept control frames
  } rxAddrCfg_t;

  typedef struct packed
  {
    logic                    AddressMiss;
    logic                    Aborted;
    logic                    Broadcast;
    logic                    Multicast;
    logic [ByteCntWidth-1:0] Length;                        // Bytes after the delimiter
  } rxFrameStatus_t;

endpackage

`default_nettype wire

/* ethRxStateMachine.sv */
`default_nettype none

module ethRxStateMachine
(
  input  wire                MRxClk,
  input  wire                Reset,
  input  wire                RxDv,
  input  wire [7:0]          RxByte,
  input  wire                RxAbort,
  output logic               StateData,
  output logic               SfdSeen,
  output logic               RxEndFrm,
  output ethRxPkg::rxState_t State
);

  ethRxPkg::rxState_t NextState;

  always_comb
  begin
    NextState = State;
    unique case (State)
      ethRxPkg::Idle:
        if (RxDv && RxByte == ethRxPkg::PreambleByte)
          NextState = ethRxPkg::Preamble;
      ethRxPkg::Preamble:
        if (!RxDv)
          NextState = ethRxPkg::Idle;
        else if (RxByte == ethRxPkg::SfdByte)
          NextState = ethRxPkg::Data;                       // Other bytes keep us hunting for the SFD
      ethRxPkg::Data:
        if (!RxDv)
          NextState = ethRxPkg::Idle;
        else if (RxAbort)
          NextState = ethRxPkg::Drop;
      ethRxPkg::Drop:
        if (!RxDv)
          NextState = ethRxPkg::Idle;
    endcase
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      State <= ethRxPkg::Idle;
    else
      State <= NextState;
  end

  assign StateData = (State == ethRxPkg::Data);

  assign SfdSeen = (State == ethRxPkg::Preamble) && RxDv && (RxByte == ethRxPkg::SfdByte);

  // The state still shows Data or Drop in the first cycle with RxDv low,
  // so this is high for exactly one cycle at the end of every started frame
  assign RxEndFrm = ((State == ethRxPkg::Data) || (State == ethRxPkg::Drop)) && !RxDv;

  // A frame end is only possible after a delimiter was found
  assert property (@(posedge MRxClk) disable iff (Reset)
    (State == ethRxPkg::Idle) |=> !RxEndFrm)
    else $error("RxEndFrm directly after Idle");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the receive address filter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tbEthRxAddrFilter -o simEthRxAddrFilter
./obj_dir/simEthRxAddrFilter

/* tbEthRxAddrFilter.sv */
`default_nettype none

module tbEthRxAddrFilter;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumFrames     = 200;
  localparam int TimeoutCycles = NumFrames * 50;            // Frames average well under 50 cycles

  logic                     MRxClk;
  logic                     Reset;
  logic                     RxDv;
  logic [7:0]               RxByte;
  ethRxPkg::rxAddrCfg_t     Cfg;
  logic                     RxAbort;
  logic                     RxStatusValid;
  ethRxPkg::rxFrameStatus_t RxStatus;

  ethRxPkg::rxFrameStatus_t expQueue[$];                    // One entry per frame sent
  logic [31:0]              rngState = 32'hA69D_9110;
  int                       cycleCnt = 0;
  int                       sfdCycle = -100;                // Cycle in which the SFD was on RxByte
  logic                     expAbort = 1'b0;
  int                       statusCount = 0;
  int                       abortCount = 0;

  ethRxAddrFilter u_ethRxAddrFilter
  (
    .MRxClk        (MRxClk),
    .Reset         (Reset),
    .RxDv          (RxDv),
    .RxByte        (RxByte),
    .Cfg           (Cfg),
    .RxAbort       (RxAbort),
    .RxStatusValid (RxStatusValid),
    .RxStatus      (RxStatus)
  );

  initial
  begin
    MRxClk = 1'b0;
    forever #4 MRxClk = ~MRxClk;
  end

  task automatic stopOnFailure(input string msg);
    $display("TEST FAILED");
    $fatal(1, "%s", msg);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // Reflected CRC-32 from all ones over the six destination bytes, hash is the top six bits
  function automatic logic [5:0] hashOfDest(input logic [47:0] dest);
    logic [31:0] crc;
    logic        feedback;
    int          b;
    int          i;
    crc = 32'hFFFF_FFFF;
    for (b = 0; b < 6; b++)
    begin
      for (i = 0; i < 8; i++)
      begin
        feedback = crc[0] ^ dest[40 - 8 * b + i];           // Each byte goes out LSB first
        crc = {1'b0, crc[31:1]} ^ (feedback ? ethRxPkg::CrcPoly : 32'h0);
      end
    end
    return crc[31:26];
  endfunction

  task automatic driveByte(input logic dv, input logic [7:0] value);
    @(posedge MRxClk);
    #1;
    RxDv   = dv;
    RxByte = value;
  endtask

  task automatic sendFrame(input logic [47:0] dest, input int len, input int gap);
    logic [31:0] r;
    int          i;
    for (i = 0; i < 7; i++)
      driveByte(1'b1, ethRxPkg::PreambleByte);
    driveByte(1'b1, ethRxPkg::SfdByte);
    sfdCycle = cycleCnt;
    for (i = 0; i < len; i++)
    begin
      r = nextRandom();
      if (i < 6)
        driveByte(1'b1, dest[47 - 8 * i -: 8]);
      else
        driveByte(1'b1, r[7:0]);                            // Source address and payload
    end
    for (i = 0; i < gap; i++)
      driveByte(1'b0, 8'h00);
  endtask

  task automatic checkStatus();
    ethRxPkg::rxFrameStatus_t exp;
    assert (expQueue.size() > 0)
      else stopOnFailure("RxStatusValid pulsed although no frame was outstanding");
    exp = expQueue.pop_front();
    assert (RxStatus == exp)
      else stopOnFailure($sformatf(
        "Error at %0t: status miss/abort/bc/mc %b%b%b%b len %0d, expected %b%b%b%b len %0d",
        $time, RxStatus.AddressMiss, RxStatus.Aborted, RxStatus.Broadcast, RxStatus.Multicast,
        RxStatus.Length, exp.AddressMiss, exp.Aborted, exp.Broadcast, exp.Multicast, exp.Length));
    statusCount++;
  endtask

  always @(posedge MRxClk)
  begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles)
      stopOnFailure($sformatf("Timeout after %0d cycles, the frames never all completed",
                              cycleCnt));
  end

  // Outputs are registered, so the middle of the cycle is a safe place to look
  always @(negedge MRxClk)
  begin
    if (!Reset)
    begin
      if (cycleCnt == sfdCycle + 8)
        assert (RxAbort == expAbort)
          else stopOnFailure($sformatf(
            "Error at %0t: RxAbort %0b in the ByteCnt-8 cycle, expected %0b",
            $time, RxAbort, expAbort));
      else
        assert (!RxAbort)
          else stopOnFailure($sformatf(
            "Error at %0t: RxAbort high outside the ByteCnt-8 cycle", $time));
      if (RxStatusValid)
        checkStatus();
    end
  end

  initial
  begin
    ethRxPkg::rxAddrCfg_t     cfg;
    ethRxPkg::rxFrameStatus_t exp;
    logic [47:0]              dest;
    logic [31:0]              r1;
    logic [31:0]              r2;
    logic [31:0]              hashWord;
    logic [5:0]               hash;
    logic                     isBcast;
    logic                     accepted;
    int                       len;
    int                       f;
    $timeformat(-9, 1, " ns", 0);
    Reset  = 1'b1;
    RxDv   = 1'b0;
    RxByte = 8'h00;
    Cfg    = '0;
    repeat (5) @(posedge MRxClk);
    #1;
    Reset = 1'b0;
    for (f = 0; f < NumFrames; f++)
    begin
      r1 = nextRandom();
      r2 = nextRandom();
      cfg.Mac     = {r1[15:9], 1'b0, r1[7:0], r2};          // Station addresses are unicast
      cfg.Hash0   = nextRandom();
      cfg.Hash1   = nextRandom();
      r1          = nextRandom();
      cfg.RBro    = r1[0];
      cfg.RPro    = (r1[2:1] == 2'b00);
      cfg.PassAll = r1[3];
      Cfg         = cfg;                                    // Line is idle here
      r2 = nextRandom();
      case (r1[31:8] % 5)
        0:       dest = cfg.Mac;
        1:       dest = 48'hFFFF_FFFF_FFFF;
        2:       dest = ethRxPkg::ControlAddr;
        3:       dest = {r2[15:9], 1'b1, r2[7:0], nextRandom()};
        default: dest = {r2[15:9], 1'b0, r2[7:0], nextRandom()};
      endcase
      len = 12 + int'(nextRandom() % 29);

      isBcast  = (dest == 48'hFFFF_FFFF_FFFF);
      hash     = hashOfDest(dest);
      hashWord = hash[5] ? cfg.Hash1 : cfg.Hash0;
      accepted = (dest == cfg.Mac) || (isBcast && !cfg.RBro) ||
                 (dest[40] && !isBcast && hashWord[hash[4:0]]);
      expAbort = !(accepted || cfg.RPro);
      exp.AddressMiss = !(accepted || (cfg.PassAll && dest == ethRxPkg::ControlAddr));
      exp.Aborted     = expAbort;
      exp.Broadcast   = isBcast;
      exp.Multicast   = dest[40];
      exp.Length      = len[ethRxPkg::ByteCntWidth-1:0];
      expQueue.push_back(exp);
      if (expAbort)
        abortCount++;
      sendFrame(dest, len, 3 + int'(nextRandom() % 3));
    end
    while (statusCount < NumFrames)
      @(posedge MRxClk);
    repeat (4) @(posedge MRxClk);                           // Room for a stray extra status
    $display("Frames sent %0d, aborted %0d", NumFrames, abortCount);
    if (expQueue.size() == 0 && statusCount == NumFrames)
    begin
      $display("TEST PASSED");
      $finish;
    end
    else
      stopOnFailure($sformatf("Received %0d statuses for %0d frames", statusCount, NumFrames));
  end

endmodule

`default_nettype wire

/* vlog.f */
ethRxPkg.sv
ethRxStateMachine.sv
ethRxDataPath.sv
ethCrc.sv
ethRxAddrCheck.sv
ethRxAddrFilter.sv
tbEthRxAddrFilter.sv
